//--- build.f
+incdir+logic
+incdir+bench
logic/ahb_pkg.sv
logic/wb_pkg.sv
logic/ahb_req_capture.sv
logic/ahb_wb_bridge.sv
logic/wb_scratch_slave.sv
logic/ahb_wb_top.sv
bench/tb_ahb_wb_top.sv

//--- Makefile
# Verilator simulation of the AHB to Wishbone bridge

TOP := tb_ahb_wb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q '\*\* PASS \*\*' run.log

clean:
	rm -rf obj_dir run.log

//--- bench/tb_checks.svh
// compare tasks, one per kind of DUT result

task automatic check_data(input string name, input ahb_pkg::hdata_t got,
                          input ahb_pkg::hdata_t exp);
   n_checks++;
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
      n_errors++;
   end
endtask

task automatic check_resp(input string name, input ahb_pkg::hresp_e got,
                          input ahb_pkg::hresp_e exp);
   n_checks++;
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h (%s) expected 0x%0h (%s)",
               name, got, got.name(), exp, exp.name());
      n_errors++;
   end
endtask

task automatic check_irq(input string name, input logic got, input logic exp);
   n_checks++;
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      n_errors++;
   end
endtask

task automatic check_ready(input string name, input logic got, input logic exp);
   n_checks++;
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
      n_errors++;
   end
endtask

//--- bench/tb_ahb_wb_top.sv
`include "bridge_defs.svh"

module tb_ahb_wb_top;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int N_FILL       = `BRIDGE_RAM_WORDS;
   localparam int N_PARTIAL    = 24;
   localparam int N_RETRY      = 8;
   localparam int N_ERR        = 8;
   localparam int N_TRANSFERS  = 2 * (N_FILL + N_PARTIAL + N_ERR) + 3 * N_RETRY + 4;
   localparam int RESP_LIMIT   = 20;   // cycles of hready_o low before giving up

   logic            hclk;
   logic            hresetn;
   logic            hsel;
   ahb_pkg::haddr_t haddr;
   logic            hwrite;
   ahb_pkg::hsize_t hsize;
   ahb_pkg::hdata_t hwdata;
   logic            hready;
   ahb_pkg::hresp_e hresp;
   ahb_pkg::hdata_t hrdata;
   logic            irq;

   logic [31:0]     rng;
   logic [31:0]     rnd;
   ahb_pkg::haddr_t addr;
   ahb_pkg::hsize_t size;
   ahb_pkg::hdata_t wdata;
   ahb_pkg::hdata_t model_ram [`BRIDGE_RAM_WORDS];
   logic [15:0]     model_retry;   // one flag per aliased word
   logic            model_irq;
   int              n_checks;
   int              n_errors;
   int              mark;          // error count when a test starts

   `include "tb_checks.svh"

   ahb_wb_top i_ahb_wb_top (
      .hclk        (hclk),
      .hresetn     (hresetn),
      .hsel_i      (hsel),
      .hready_ba_i (hready),   // bus hready is the bridge's own
      .haddr_i     (haddr),
      .hwrite_i    (hwrite),
      .hsize_i     (hsize),
      .hwdata_i    (hwdata),
      .hready_o    (hready),
      .hresp_o     (hresp),
      .hrdata_o    (hrdata),
      .irq_o       (irq)
   );

   initial begin
      hclk = 1'b0;
      forever #(CLK_PERIOD / 2) hclk = ~hclk;
   end

   initial begin
      #(CLK_PERIOD * (N_TRANSFERS * 12 + RESET_CYCLES));
      $display("watchdog expired before the tests completed");
      $display("** FAIL **");
      $finish;
   end

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x   = rng;
      x   = x ^ (x << 13);
      x   = x ^ (x >> 17);
      x   = x ^ (x << 5);
      rng = x;
      return x;
   endfunction

   // little endian lanes covered by a transfer
   function automatic logic [3:0] lanes_for(input ahb_pkg::hsize_t sz, input logic [1:0] offs);
      logic [3:0] lanes;
      int         nbytes;
      nbytes = 1 << sz;
      lanes  = '0;
      for (int b = 0; b < 4; b++) begin
         if (b >= offs && b < offs + nbytes)
            lanes[b] = 1'b1;
      end
      return lanes;
   endfunction

   task automatic model_access(input ahb_pkg::haddr_t a, input logic wr,
                               input ahb_pkg::hsize_t sz, input ahb_pkg::hdata_t wd,
                               output ahb_pkg::hresp_e exp_resp,
                               output ahb_pkg::hdata_t exp_rdata);
      logic [3:0] lanes;
      logic       mem;
      lanes     = lanes_for(sz, a[1:0]);
      mem       = 1'b0;
      exp_resp  = ahb_pkg::HRESP_OKAY;
      exp_rdata = '0;
      if (a < `BRIDGE_RETRY_BASE) begin
         mem = 1'b1;
      end else if (a < `BRIDGE_ERR_BASE) begin
         mem = model_retry[a[5:2]];   // reissue goes through
         if (!mem)
            exp_resp = ahb_pkg::HRESP_RETRY;
         model_retry[a[5:2]] = !mem;
      end else if (a >= `BRIDGE_IRQ_ADDR) begin
         exp_rdata = {31'b0, model_irq};
         if (wr && lanes[0])
            model_irq = wd[0];
      end else begin
         exp_resp = ahb_pkg::HRESP_ERROR;
      end
      if (mem) begin
         exp_rdata = model_ram[a[6:2]];   // old word comes back
         for (int b = 0; b < 4; b++) begin
            if (wr && lanes[b])
               model_ram[a[6:2]][8*b +: 8] = wd[8*b +: 8];
         end
      end
   endtask

   // one AHB transfer that returns at the negedge where hready_o is seen high
   task automatic drive_transfer(input ahb_pkg::haddr_t a, input logic wr,
                                 input ahb_pkg::hsize_t sz, input ahb_pkg::hdata_t wd,
                                 output ahb_pkg::hresp_e wait_resp,
                                 output ahb_pkg::hresp_e resp,
                                 output ahb_pkg::hdata_t rdata);
      int   low_cycles;
      logic done;
      low_cycles = 0;
      done       = 1'b0;
      wait_resp  = ahb_pkg::HRESP_OKAY;
      resp       = ahb_pkg::HRESP_OKAY;
      rdata      = '0;
      @(posedge hclk);
      hsel   <= 1'b1;
      haddr  <= a;
      hwrite <= wr;
      hsize  <= sz;
      @(posedge hclk);   // address phase accepted
      hsel   <= 1'b0;
      hwdata <= wd;
      @(posedge hclk);   // write data taken
      while (!done) begin
         @(negedge hclk);
         if (hready) begin
            resp  = hresp;
            rdata = hrdata;
            done  = 1'b1;
         end else begin
            wait_resp = hresp;   // last code seen with hready_o low
            low_cycles++;
            if (low_cycles > RESP_LIMIT) begin
               $display("transfer to 0x%02h got no response within %0d cycles", a, RESP_LIMIT);
               n_errors++;
               done = 1'b1;
            end
         end
      end
      if (low_cycles == 0) begin
         $display("hready_o never went low for the transfer to 0x%02h", a);
         n_errors++;
      end
   endtask

   task automatic issue_access(input ahb_pkg::haddr_t a, input logic wr,
                               input ahb_pkg::hsize_t sz, input ahb_pkg::hdata_t wd);
      ahb_pkg::hresp_e exp_resp;
      ahb_pkg::hdata_t exp_rdata;
      ahb_pkg::hresp_e wait_resp;
      ahb_pkg::hresp_e resp;
      ahb_pkg::hdata_t rdata;
      model_access(a, wr, sz, wd, exp_resp, exp_rdata);
      drive_transfer(a, wr, sz, wd, wait_resp, resp, rdata);
      check_resp($sformatf("hresp_o @%02h", a), resp, exp_resp);
      check_resp($sformatf("hresp_o (hready_o low) @%02h", a), wait_resp, exp_resp);
      if (!wr && exp_resp == ahb_pkg::HRESP_OKAY)
         check_data($sformatf("hrdata_o @%02h", a), rdata, exp_rdata);
   endtask

   task automatic report_test(input string name);
      $display("test %-14s done, %0d errors", name, n_errors - mark);
   endtask

   initial begin
      hresetn     = 1'b0;
      hsel        = 1'b0;
      haddr       = '0;
      hwrite      = 1'b0;
      hsize       = ahb_pkg::HSIZE_WORD;
      hwdata      = '0;
      rng         = 32'h5262_11bc;
      model_retry = '0;
      model_irq   = 1'b0;
      n_checks    = 0;
      n_errors    = 0;
      repeat (RESET_CYCLES) @(posedge hclk);
      hresetn <= 1'b1;

      mark = n_errors;
      @(negedge hclk);
      check_ready("hready_o", hready, 1'b1);
      check_resp("hresp_o", hresp, ahb_pkg::HRESP_OKAY);
      check_irq("irq_o", irq, 1'b0);
      report_test("reset state");

      // every RAM word gets a value before the random reads
      mark = n_errors;
      for (int w = 0; w < N_FILL; w++) begin
         issue_access({1'b0, w[4:0], 2'b00}, 1'b1, ahb_pkg::HSIZE_WORD, xorshift32());
      end
      for (int r = 0; r < N_FILL; r++) begin
         rnd = xorshift32();
         issue_access({1'b0, rnd[4:0], 2'b00}, 1'b0, ahb_pkg::HSIZE_WORD, '0);
      end
      report_test("ram words");

      mark = n_errors;
      for (int i = 0; i < N_PARTIAL; i++) begin
         rnd  = xorshift32();
         size = rnd[8] ? ahb_pkg::HSIZE_HALF : ahb_pkg::HSIZE_BYTE;
         addr = {1'b0, rnd[6:2], rnd[1], rnd[0] & ~rnd[8]};   // halfwords stay aligned
         issue_access(addr, 1'b1, size, xorshift32());
         issue_access({addr[7:2], 2'b00}, 1'b0, ahb_pkg::HSIZE_WORD, '0);
      end
      report_test("byte lanes");

      mark = n_errors;
      for (int i = 0; i < N_RETRY; i++) begin
         rnd   = xorshift32();
         addr  = {2'b10, rnd[5:2], 2'b00};
         wdata = xorshift32();
         issue_access(addr, rnd[9], ahb_pkg::HSIZE_WORD, wdata);   // retried
         issue_access(addr, rnd[9], ahb_pkg::HSIZE_WORD, wdata);   // completes
         issue_access({1'b0, addr[6:2], 2'b00}, 1'b0, ahb_pkg::HSIZE_WORD, '0);
      end
      report_test("retry alias");

      mark = n_errors;
      for (int i = 0; i < N_ERR; i++) begin
         rnd  = xorshift32();
         addr = {2'b11, rnd[5:2], 2'b00};
         if (addr == `BRIDGE_IRQ_ADDR)
            addr = 8'hF8;
         issue_access(addr, rnd[9], ahb_pkg::HSIZE_WORD, xorshift32());
         issue_access({1'b0, addr[6:2], 2'b00}, 1'b0, ahb_pkg::HSIZE_WORD, '0);
      end
      report_test("error region");

      mark = n_errors;
      issue_access(`BRIDGE_IRQ_ADDR, 1'b1, ahb_pkg::HSIZE_WORD, 32'h0000_0001);
      @(negedge hclk);
      check_irq("irq_o", irq, 1'b1);
      issue_access(`BRIDGE_IRQ_ADDR, 1'b0, ahb_pkg::HSIZE_WORD, '0);
      rnd = xorshift32();
      issue_access(`BRIDGE_IRQ_ADDR, 1'b1, ahb_pkg::HSIZE_WORD, {rnd[31:1], 1'b0});
      @(negedge hclk);
      check_irq("irq_o", irq, 1'b0);
      issue_access(`BRIDGE_IRQ_ADDR, 1'b0, ahb_pkg::HSIZE_WORD, '0);
      report_test("interrupt");

      $display("summary: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- logic/ahb_wb_top.sv
module ahb_wb_top (
   input  logic            hclk,
   input  logic            hresetn,
   input  logic            hsel_i,
   input  logic            hready_ba_i,
   input  ahb_pkg::haddr_t haddr_i,
   input  logic            hwrite_i,
   input  ahb_pkg::hsize_t hsize_i,
   input  ahb_pkg::hdata_t hwdata_i,
   output logic            hready_o,
   output ahb_pkg::hresp_e hresp_o,
   output ahb_pkg::hdata_t hrdata_o,
   output logic            irq_o
);

   logic              start;
   ahb_pkg::ahb_req_t req;
   wb_pkg::wb_req_t   wb_req;
   wb_pkg::wb_rsp_t   wb_rsp;

   ahb_req_capture i_capture (
      .hclk        (hclk),
      .hresetn     (hresetn),
      .hsel_i      (hsel_i),
      .hready_ba_i (hready_ba_i),
      .haddr_i     (haddr_i),
      .hwrite_i    (hwrite_i),
      .hsize_i     (hsize_i),
      .hwdata_i    (hwdata_i),
      .start_o     (start),
      .req_o       (req)
   );

   ahb_wb_bridge i_bridge (
      .hclk        (hclk),
      .hresetn     (hresetn),
      .start_i     (start),
      .req_i       (req),
      .hready_ba_i (hready_ba_i),
      .wb_o        (wb_req),
      .wb_i        (wb_rsp),
      .hready_o    (hready_o),
      .hresp_o     (hresp_o),
      .hrdata_o    (hrdata_o),
      .irq_o       (irq_o)
   );

   wb_scratch_slave i_slave (
      .hclk    (hclk),
      .hresetn (hresetn),
      .wb_i    (wb_req),
      .wb_o    (wb_rsp)
   );

endmodule

//--- logic/wb_scratch_slave.sv
`include "bridge_defs.svh"

module wb_scratch_slave (
   input  logic            hclk,
   input  logic            hresetn,
   input  wb_pkg::wb_req_t wb_i,
   output wb_pkg::wb_rsp_t wb_o
);

   localparam int LANES       = `BRIDGE_DW / 8;
   localparam int WORD_BITS   = $clog2(`BRIDGE_RAM_WORDS);
   localparam int RETRY_WORDS = (`BRIDGE_ERR_BASE - `BRIDGE_RETRY_BASE) / 4;
   localparam int FLAG_BITS   = $clog2(RETRY_WORDS);

   typedef logic [1:0] wait_t;

   wb_pkg::wb_dat_t        ram [`BRIDGE_RAM_WORDS];
   logic [RETRY_WORDS-1:0] retry_q;   // set by a retry, cleared on completion
   wait_t                  cnt_q;
   wait_t                  wait_n;
   logic                   ack_q;
   logic                   err_q;
   logic                   rty_q;
   logic                   irq_q;
   wb_pkg::wb_dat_t        rdat_q;
   logic                   in_ram;
   logic                   in_retry;
   logic                   in_irq;
   logic                   term;
   logic                   due;
   logic                   mem_ok;
   logic [WORD_BITS-1:0]   word_idx;
   logic [FLAG_BITS-1:0]   flag_idx;

   // region decode
   assign in_ram   = wb_i.adr < `BRIDGE_RETRY_BASE;
   assign in_retry = (wb_i.adr >= `BRIDGE_RETRY_BASE) && (wb_i.adr < `BRIDGE_ERR_BASE);
   assign in_irq   = {wb_i.adr[`BRIDGE_AW-1:2], 2'b00} == `BRIDGE_IRQ_ADDR;
   assign word_idx = wb_i.adr[WORD_BITS+1:2];   // alias folds onto the low words
   assign flag_idx = wb_i.adr[FLAG_BITS+1:2];

   assign wait_n = wait_t'((wb_i.adr & `BRIDGE_WAIT_MASK) >> `BRIDGE_WAIT_SHIFT);
   assign term   = ack_q | err_q | rty_q;
   assign due    = wb_i.cyc & wb_i.stb & ~term & (cnt_q == wait_n);
   assign mem_ok = in_ram | (in_retry & retry_q[flag_idx]);

   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn) begin
         cnt_q   <= '0;
         ack_q   <= 1'b0;
         err_q   <= 1'b0;
         rty_q   <= 1'b0;
         retry_q <= '0;
         irq_q   <= 1'b0;
      end else begin
         ack_q <= 1'b0;   // single cycle pulses
         err_q <= 1'b0;
         rty_q <= 1'b0;
         if (wb_i.cyc && wb_i.stb && !term && !due)
            cnt_q <= cnt_q + 1'b1;
         if (due) begin
            cnt_q <= '0;
            if (in_ram || in_irq) begin
               ack_q <= 1'b1;
            end else if (in_retry) begin
               ack_q             <= retry_q[flag_idx];
               rty_q             <= ~retry_q[flag_idx];
               retry_q[flag_idx] <= ~retry_q[flag_idx];
            end else begin
               err_q <= 1'b1;
            end
            if (in_irq && wb_i.we && wb_i.sel[0])
               irq_q <= wb_i.dat[0];
         end
      end
   end

   // RAM with byte lanes
   always_ff @(posedge hclk) begin
      if (due && mem_ok) begin
         for (int b = 0; b < LANES; b++) begin
            if (wb_i.we && wb_i.sel[b])
               ram[word_idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
         end
         rdat_q <= ram[word_idx];
      end else if (due && in_irq) begin
         rdat_q <= wb_pkg::wb_dat_t'(irq_q);
      end
   end

   assign wb_o.dat  = rdat_q;
   assign wb_o.ack  = ack_q;
   assign wb_o.err  = err_q;
   assign wb_o.rty  = rty_q;
   assign wb_o.inta = irq_q;

   a_stb_terminated: assert property (@(posedge hclk) disable iff (!hresetn)
      $fell(wb_i.stb) |-> $past(term))
      else $error("wishbone strobe dropped without ack, err or rty");

endmodule

//--- logic/ahb_wb_bridge.sv
module ahb_wb_bridge (
   input  logic              hclk,
   input  logic              hresetn,
   input  logic              start_i,
   input  ahb_pkg::ahb_req_t req_i,
   input  logic              hready_ba_i,
   output wb_pkg::wb_req_t   wb_o,
   input  wb_pkg::wb_rsp_t   wb_i,
   output logic              hready_o,
   output ahb_pkg::hresp_e   hresp_o,
   output ahb_pkg::hdata_t   hrdata_o,
   output logic              irq_o
);

   typedef enum logic [1:0] {
      IDLE,
      SELECTED,   // wishbone cycle running
      RESP_1,     // first cycle of error or retry
      RESP_2
   } state_e;

   state_e          state_q;
   state_e          state_n;
   logic            hready_q;
   logic            hready_n;
   ahb_pkg::hresp_e hresp_q;
   ahb_pkg::hresp_e hresp_n;
   logic            launch;
   logic            term;
   logic            cyc_q;
   logic            stb_q;
   logic            we_q;
   wb_pkg::wb_adr_t adr_q;
   wb_pkg::wb_dat_t dat_q;
   wb_pkg::wb_sel_t sel_q;

   assign launch = (state_q == IDLE) && start_i;
   assign term   = wb_i.ack | wb_i.err | wb_i.rty;

   // response FSM
   always_comb begin
      state_n  = state_q;
      hready_n = hready_q;
      hresp_n  = hresp_q;
      case (state_q)
         IDLE: begin
            if (start_i) begin
               state_n  = SELECTED;
               hready_n = 1'b0;
            end
         end
         SELECTED: begin
            if (wb_i.err || wb_i.rty) begin
               state_n = RESP_1;
               hresp_n = wb_i.err ? ahb_pkg::HRESP_ERROR : ahb_pkg::HRESP_RETRY;
            end else if (wb_i.ack) begin
               state_n  = IDLE;
               hready_n = 1'b1;
               hresp_n  = ahb_pkg::HRESP_OKAY;
            end
         end
         RESP_1: begin
            state_n  = RESP_2;
            hready_n = 1'b1;   // code stays for the second cycle
         end
         RESP_2: begin
            if (hready_ba_i) begin   // bus has sampled the response
               state_n = IDLE;
               hresp_n = ahb_pkg::HRESP_OKAY;
            end
         end
         default: state_n = IDLE;
      endcase
   end

   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn) begin
         state_q  <= IDLE;
         hready_q <= 1'b1;
         hresp_q  <= ahb_pkg::HRESP_OKAY;
         cyc_q    <= 1'b0;
         stb_q    <= 1'b0;
         we_q     <= 1'b0;
         irq_o    <= 1'b0;
      end else begin
         state_q  <= state_n;
         hready_q <= hready_n;
         hresp_q  <= hresp_n;
         irq_o    <= wb_i.inta;
         if (launch) begin
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
            we_q  <= req_i.write;
         end else if (stb_q && term) begin   // any termination ends the cycle
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            we_q  <= 1'b0;
         end
      end
   end

   always_ff @(posedge hclk) begin
      if (launch) begin
         adr_q <= req_i.addr;
         dat_q <= req_i.wdata;
         sel_q <= req_i.sel;
      end
      if (state_q == SELECTED && wb_i.ack)
         hrdata_o <= wb_i.dat;
   end

   assign wb_o.adr = adr_q;
   assign wb_o.dat = dat_q;
   assign wb_o.sel = sel_q;
   assign wb_o.we  = we_q;
   assign wb_o.cyc = cyc_q;
   assign wb_o.stb = stb_q;

   // wait state begins as soon as the capture block flags a transfer
   assign hready_o = hready_q & ~start_i;
   assign hresp_o  = hresp_q;

   a_stb_in_cyc: assert property (@(posedge hclk) disable iff (!hresetn)
      wb_o.stb |-> wb_o.cyc);

   a_one_term: assert property (@(posedge hclk) disable iff (!hresetn)
      $onehot0({wb_i.ack, wb_i.err, wb_i.rty}))
      else $error("more than one wishbone termination at once");

   a_idle_ready: assert property (@(posedge hclk) disable iff (!hresetn)
      (state_q == IDLE) && !start_i |-> hready_o);

endmodule

//--- logic/ahb_req_capture.sv
`include "bridge_defs.svh"

module ahb_req_capture (
   input  logic              hclk,
   input  logic              hresetn,
   input  logic              hsel_i,
   input  logic              hready_ba_i,
   input  ahb_pkg::haddr_t   haddr_i,
   input  logic              hwrite_i,
   input  ahb_pkg::hsize_t   hsize_i,
   input  ahb_pkg::hdata_t   hwdata_i,
   output logic              start_o,
   output ahb_pkg::ahb_req_t req_o
);

   logic             accept;
   logic             pend_q;     // data phase in progress
   ahb_pkg::haddr_t  addr_q;
   logic             write_q;
   ahb_pkg::hlanes_t sel_n;
   ahb_pkg::hlanes_t sel_q;

   assign accept = hsel_i & hready_ba_i;

   // little endian byte lanes
   always_comb begin
      case (hsize_i)
         ahb_pkg::HSIZE_BYTE: sel_n = ahb_pkg::hlanes_t'(1) << haddr_i[1:0];
         ahb_pkg::HSIZE_HALF: sel_n = haddr_i[1] ? 4'b1100 : 4'b0011;
         default:             sel_n = '1;
      endcase
   end

   always_ff @(posedge hclk or negedge hresetn) begin
      if (!hresetn) begin
         pend_q  <= 1'b0;
         start_o <= 1'b0;
      end else begin
         pend_q  <= accept;
         start_o <= pend_q;   // one cycle strobe after write data is in
      end
   end

   // address phase fields, then merged with hwdata one cycle later
   always_ff @(posedge hclk) begin
      if (accept) begin
         addr_q  <= haddr_i;
         write_q <= hwrite_i;
         sel_q   <= sel_n;
      end
      if (pend_q)
         req_o <= '{addr: addr_q, write: write_q, sel: sel_q, wdata: hwdata_i};
   end

   a_size_legal: assert property (@(posedge hclk) disable iff (!hresetn)
      accept |-> hsize_i <= ahb_pkg::HSIZE_WORD)
      else $error("hsize above word on an accepted transfer");

endmodule

//--- logic/wb_pkg.sv
`include "bridge_defs.svh"

package wb_pkg;

   typedef logic [`BRIDGE_AW-1:0]   wb_adr_t;
   typedef logic [`BRIDGE_DW-1:0]   wb_dat_t;
   typedef logic [`BRIDGE_DW/8-1:0] wb_sel_t;   // byte lanes

   // master to slave
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    we;
      logic    cyc;
      logic    stb;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      wb_dat_t dat;
      logic    ack;
      logic    err;
      logic    rty;
      logic    inta;
   } wb_rsp_t;

endpackage

//--- logic/ahb_pkg.sv
`include "bridge_defs.svh"

package ahb_pkg;

   typedef logic [`BRIDGE_AW-1:0]   haddr_t;   // byte address
   typedef logic [`BRIDGE_DW-1:0]   hdata_t;
   typedef logic [2:0]              hsize_t;
   typedef logic [`BRIDGE_DW/8-1:0] hlanes_t;  // one bit per byte lane

   // transfer size codes
   localparam hsize_t HSIZE_BYTE = 3'd0;
   localparam hsize_t HSIZE_HALF = 3'd1;
   localparam hsize_t HSIZE_WORD = 3'd2;

   // slave response, split is not supported
   typedef enum logic [1:0] {
      HRESP_OKAY  = 2'b00,
      HRESP_ERROR = 2'b01,
      HRESP_RETRY = 2'b10
   } hresp_e;

   // one captured transfer
   typedef struct packed {
      haddr_t  addr;
      logic    write;
      hlanes_t sel;
      hdata_t  wdata;
   } ahb_req_t;

endpackage

//--- logic/bridge_defs.svh
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// bus widths
`define BRIDGE_AW 8
`define BRIDGE_DW 32

// scratch RAM depth in words
`define BRIDGE_RAM_WORDS 32

// region bounds of the scratch slave
`define BRIDGE_RETRY_BASE 8'h80   // alias of the RAM, first access retried
`define BRIDGE_ERR_BASE   8'hC0   // everything up to the irq word answers err
`define BRIDGE_IRQ_ADDR   8'hFC

// address bits that select 0..3 wait states
`define BRIDGE_WAIT_MASK  8'h0C
`define BRIDGE_WAIT_SHIFT 2

`endif
